// ==== arithmeticUnit.sv ====
module arithmeticUnit (
    input  datapathPkg::opcode_t   opcode,
    input  datapathPkg::word_t     operandA,
    input  datapathPkg::word_t     operandB,
    output datapathPkg::product_t  result
);
    import datapathPkg::*;

    logic [4:0]         shiftAmount;
    product_t           rotateRight;
    product_t           rotateLeft;
    logic signed [63:0] signedProduct;
    word_t              quotient;
    word_t              remainder;
    word_t              wordResult;

    assign shiftAmount = operandB[4:0];

    // A doubled up, so a plain shift gives the rotate in one half
    assign rotateRight = {operandA, operandA} >> shiftAmount;
    assign rotateLeft  = {operandA, operandA} << shiftAmount;

    assign signedProduct = $signed(operandA) * $signed(operandB);  // operands sign-extend to 64

    always_comb begin
        if (operandB == '0) begin
            quotient  = '0;  // divide by zero reads as zero
            remainder = '0;
        end else begin
            quotient  = $signed(operandA) / $signed(operandB);
            remainder = $signed(operandA) % $signed(operandB);
        end
    end

    always_comb begin
        case (opcode)
            opAdd:   wordResult = operandA + operandB;
            opSub:   wordResult = operandA - operandB;
            opAnd:   wordResult = operandA & operandB;
            opOr:    wordResult = operandA | operandB;
            opShr:   wordResult = operandA >> shiftAmount;
            opShra:  wordResult = $signed(operandA) >>> shiftAmount;
            opShl:   wordResult = operandA << shiftAmount;
            opRor:   wordResult = rotateRight[31:0];
            opRol:   wordResult = rotateLeft[63:32];
            opNeg:   wordResult = -operandB;  // unary ops take the bus operand
            opNot:   wordResult = ~operandB;
            default: wordResult = '0;
        endcase
    end

    // only mul and div fill the high word
    always_comb begin
        case (opcode)
            opMul:   result = signedProduct;
            opDiv:   result = {remainder, quotient};
            default: result = {32'b0, wordResult};
        endcase
    end

endmodule

// ==== clockGen.sv ====
module clockGen (
    output logic Clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge Clock);
        #1 reset = 1'b0;  // released off the edge, like the other inputs
    end

endmodule

// ==== dataBus.sv ====
module dataBus #(
    parameter int numRegisters = 16
) (
    input  datapathPkg::busSources_t  sources,
    input  datapathPkg::word_t        registerValue,
    input  datapathPkg::word_t        pcValue,
    input  datapathPkg::word_t        zHigh,
    input  datapathPkg::word_t        zLow,
    input  datapathPkg::word_t        mdrValue,
    input  datapathPkg::word_t        hiValue,
    input  datapathPkg::word_t        loValue,
    input  datapathPkg::word_t        inPortValue,
    input  datapathPkg::word_t        irValue,
    output datapathPkg::word_t        busData
);
    import datapathPkg::*;

    word_t cValue;
    logic  anyGeneral;

    assign cValue     = {{13{irValue[18]}}, irValue[18:0]};  // 19-bit immediate field
    assign anyGeneral = |sources.generalOut[numRegisters-1:0];

    // first select in the chain wins, idle bus reads zero
    always_comb begin
        if (anyGeneral) begin
            busData = registerValue;
        end else if (sources.pcOut) begin
            busData = pcValue;
        end else if (sources.zHighOut) begin
            busData = zHigh;
        end else if (sources.zLowOut) begin
            busData = zLow;
        end else if (sources.mdrOut) begin
            busData = mdrValue;
        end else if (sources.hiOut) begin
            busData = hiValue;
        end else if (sources.loOut) begin
            busData = loValue;
        end else if (sources.inPortOut) begin
            busData = inPortValue;
        end else if (sources.cOut) begin
            busData = cValue;
        end else begin
            busData = '0;
        end
    end

endmodule

// ==== datapath.f ====
datapathPkg.sv
registerFile.sv
specialRegisters.sv
memoryInterface.sv
arithmeticUnit.sv
dataBus.sv
datapath.sv
clockGen.sv
datapathTb.sv

// ==== datapath.sv ====
module datapath #(
    parameter int numRegisters = 16
) (
    input  logic                       Clock,
    input  logic                       reset,
    input  datapathPkg::busSources_t   sources,
    input  datapathPkg::loadEnables_t  loads,
    input  datapathPkg::opcode_t       opcode,
    input  logic                       read,
    input  datapathPkg::word_t         memData,
    input  datapathPkg::word_t         inPortData,
    output datapathPkg::word_t         busData,
    output datapathPkg::word_t         marAddress,
    output datapathPkg::word_t         irValue
);
    import datapathPkg::*;

    word_t    registerValue;
    word_t    pcValue;
    word_t    yValue;
    word_t    zHigh;
    word_t    zLow;
    word_t    hiValue;
    word_t    loValue;
    word_t    inPortValue;
    word_t    mdrValue;
    product_t aluResult;

    registerFile #(
        .numRegisters (numRegisters)
    ) generalRegs (
        .Clock         (Clock),
        .reset         (reset),
        .busData       (busData),
        .generalEnable (loads.generalEnable[numRegisters-1:0]),
        .generalOut    (sources.generalOut[numRegisters-1:0]),
        .registerValue (registerValue)
    );

    specialRegisters specialRegs (
        .Clock       (Clock),
        .reset       (reset),
        .loads       (loads),
        .busData     (busData),
        .aluResult   (aluResult),
        .inPortData  (inPortData),
        .pcValue     (pcValue),
        .irValue     (irValue),
        .yValue      (yValue),
        .zHigh       (zHigh),
        .zLow        (zLow),
        .hiValue     (hiValue),
        .loValue     (loValue),
        .inPortValue (inPortValue)
    );

    memoryInterface memPort (
        .Clock      (Clock),
        .reset      (reset),
        .marEnable  (loads.marEnable),
        .mdrEnable  (loads.mdrEnable),
        .read       (read),
        .busData    (busData),
        .memData    (memData),
        .marAddress (marAddress),
        .mdrValue   (mdrValue)
    );

    arithmeticUnit alu (
        .opcode   (opcode),
        .operandA (yValue),
        .operandB (busData),  // second operand comes straight off the bus
        .result   (aluResult)
    );

    dataBus #(
        .numRegisters (numRegisters)
    ) bus (
        .sources       (sources),
        .registerValue (registerValue),
        .pcValue       (pcValue),
        .zHigh         (zHigh),
        .zLow          (zLow),
        .mdrValue      (mdrValue),
        .hiValue       (hiValue),
        .loValue       (loValue),
        .inPortValue   (inPortValue),
        .irValue       (irValue),
        .busData       (busData)
    );

endmodule

// ==== datapathPkg.sv ====
package datapathPkg;

    localparam int maxRegisters = 16;  // widest register file the control structs can address

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIndex_t;  // register field inside IR
    typedef logic [4:0]  opcode_t;
    typedef logic [63:0] product_t;  // Z width, holds mul and div results

    // ALU opcodes, numbered as in the instruction set
    localparam opcode_t opAdd  = 5'd3;
    localparam opcode_t opSub  = 5'd4;
    localparam opcode_t opAnd  = 5'd5;
    localparam opcode_t opOr   = 5'd6;
    localparam opcode_t opShr  = 5'd7;
    localparam opcode_t opShra = 5'd8;
    localparam opcode_t opShl  = 5'd9;
    localparam opcode_t opRor  = 5'd10;
    localparam opcode_t opRol  = 5'd11;
    localparam opcode_t opMul  = 5'd15;
    localparam opcode_t opDiv  = 5'd16;
    localparam opcode_t opNeg  = 5'd17;
    localparam opcode_t opNot  = 5'd18;

    typedef struct packed {
        logic                    pcOut;
        logic                    zHighOut;
        logic                    zLowOut;
        logic                    mdrOut;
        logic                    hiOut;
        logic                    loOut;
        logic                    inPortOut;
        logic                    cOut;  // sign-extended constant from IR
        logic [maxRegisters-1:0] generalOut;  // one select per general register
    } busSources_t;

    typedef struct packed {
        logic                    pcEnable;
        logic                    incPc;  // with pcEnable, PC takes bus + 1
        logic                    irEnable;
        logic                    yEnable;
        logic                    zEnable;
        logic                    hiEnable;
        logic                    loEnable;
        logic                    marEnable;
        logic                    mdrEnable;
        logic                    inPortEnable;
        logic [maxRegisters-1:0] generalEnable;
    } loadEnables_t;

endpackage

// ==== datapathTb.sv ====
module datapathTb;
    timeunit 1ns;
    timeprecision 100ps;

    import datapathPkg::*;

    localparam int cycleLimit = 400;  // roughly twice what the tests take

    logic         Clock;
    logic         reset;
    busSources_t  sources;
    loadEnables_t loads;
    opcode_t      opcode;
    logic         read;
    word_t        memData;
    word_t        inPortData;
    word_t        busData;
    word_t        marAddress;
    word_t        irValue;

    word_t   model [16];  // expected general register contents
    word_t   lfsrState = 32'h06db_7700;
    int      cycleCount = 0;
    opcode_t aluOps [13] = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
                             opRor, opRol, opMul, opDiv, opNeg, opNot};

    clockGen clocks (
        .Clock (Clock),
        .reset (reset)
    );

    datapath #(
        .numRegisters (16)
    ) DUT (
        .Clock      (Clock),
        .reset      (reset),
        .sources    (sources),
        .loads      (loads),
        .opcode     (opcode),
        .read       (read),
        .memData    (memData),
        .inPortData (inPortData),
        .busData    (busData),
        .marAddress (marAddress),
        .irValue    (irValue)
    );

    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        stopRun();
    endtask

    // nothing selected means nothing on the bus
    idleBusZero: assert property (@(posedge Clock) disable iff (reset)
        (sources == '0) |-> (busData == '0))
        else reportMismatch("idle bus", '0, $sampled(busData));

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d clock cycles", cycleLimit);
            stopRun();
        end
    end

    // Galois LFSR stepped once per bit handed out
    function automatic word_t randomBits(int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hA300_0000 : lfsrState >> 1;
        end
        return value;
    endfunction

    function automatic word_t signExtend19(word_t w);
        return w[18] ? (w | 32'hFFF8_0000) : (w & 32'h0007_FFFF);
    endfunction

    // expected Z contents for one ALU operation with A from Y and B from the bus
    function automatic product_t aluModel(opcode_t op, word_t a, word_t b);
        int     n;
        longint product;
        int     qa;
        int     qb;
        n = int'(b[4:0]);
        case (op)
            opAdd:  return {32'd0, a + b};
            opSub:  return {32'd0, a - b};
            opAnd:  return {32'd0, a & b};
            opOr:   return {32'd0, a | b};
            opShr:  return {32'd0, a >> n};
            opShra: return {32'd0, word_t'($signed(a) >>> n)};
            opShl:  return {32'd0, a << n};
            opRor:  return {32'd0, (n == 0) ? a : (a >> n) | (a << (32 - n))};
            opRol:  return {32'd0, (n == 0) ? a : (a << n) | (a >> (32 - n))};
            opMul: begin
                product = longint'($signed(a)) * longint'($signed(b));
                return product;
            end
            opDiv: begin
                if (b == '0) begin
                    return '0;
                end
                qa = $signed(a);
                qb = $signed(b);
                return {word_t'(qa % qb), word_t'(qa / qb)};  // remainder high and quotient low
            end
            opNeg:  return {32'd0, 32'd0 - b};
            opNot:  return {32'd0, ~b};
            default: return '0;
        endcase
    endfunction

    function automatic busSources_t busSelect(regIndex_t r);
        busSources_t sel;
        sel = '0;
        sel.generalOut[r] = 1'b1;
        return sel;
    endfunction

    function automatic loadEnables_t registerLoad(regIndex_t r);
        loadEnables_t en;
        en = '0;
        en.generalEnable[r] = 1'b1;
        return en;
    endfunction

    // one control step applied just after the rising edge
    task automatic drive(input busSources_t sel, input loadEnables_t en, input opcode_t op,
                         input logic rd);
        @(posedge Clock);
        #1;
        sources = sel;
        loads   = en;
        opcode  = op;
        read    = rd;
    endtask

    task automatic idleCycle();
        drive('0, '0, '0, 1'b0);
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
            else reportMismatch(name, expected, actual);
    endtask

    task automatic expectOnBus(input string name, input word_t expected);
        @(negedge Clock);
        compareWord(name, expected, busData);
    endtask

    // memory word into MDR and then over the bus into target
    task automatic moveFromMemory(input word_t value, input loadEnables_t target);
        loadEnables_t en;
        busSources_t  sel;
        en           = '0;
        en.mdrEnable = 1'b1;
        drive('0, en, '0, 1'b1);
        memData    = value;
        sel        = '0;
        sel.mdrOut = 1'b1;
        drive(sel, target, '0, 1'b0);
        expectOnBus("memory data through MDR", value);
    endtask

    task automatic loadRegister(input regIndex_t r, input word_t value);
        moveFromMemory(value, registerLoad(r));
        model[r] = value;
    endtask

    task automatic runAluOp(input string name, input opcode_t op, input regIndex_t ra,
                            input regIndex_t rb, input regIndex_t rc, input word_t a,
                            input word_t b);
        busSources_t  sel;
        loadEnables_t en;
        product_t     expected;
        loadRegister(ra, a);
        loadRegister(rb, b);
        expected = aluModel(op, model[ra], model[rb]);
        en         = '0;
        en.yEnable = 1'b1;
        drive(busSelect(ra), en, '0, 1'b0);
        expectOnBus({name, " Y load"}, model[ra]);
        en         = '0;
        en.zEnable = 1'b1;
        drive(busSelect(rb), en, op, 1'b0);
        expectOnBus({name, " Z load"}, model[rb]);
        sel         = '0;
        sel.zLowOut = 1'b1;
        drive(sel, registerLoad(rc), '0, 1'b0);
        expectOnBus({name, " ZLow"}, expected[31:0]);
        model[rc] = expected[31:0];
        if (op == opMul || op == opDiv) begin
            sel          = '0;
            sel.zHighOut = 1'b1;
            en           = '0;
            en.hiEnable  = 1'b1;
            drive(sel, en, '0, 1'b0);
            expectOnBus({name, " ZHigh"}, expected[63:32]);
            sel       = '0;
            sel.hiOut = 1'b1;
            drive(sel, '0, '0, 1'b0);
            expectOnBus({name, " HI readback"}, expected[63:32]);
        end
        drive(busSelect(rc), '0, '0, 1'b0);
        expectOnBus({name, " result register"}, model[rc]);
    endtask

    initial begin
        regIndex_t    ra;
        regIndex_t    rb;
        regIndex_t    rc;
        word_t        value;
        word_t        pcStart;
        busSources_t  sel;
        loadEnables_t en;

        sources    = '0;
        loads      = '0;
        opcode     = '0;
        read       = 1'b0;
        memData    = '0;
        inPortData = '0;
        for (int r = 0; r < 16; r++) begin
            model[r] = '0;
        end
        wait (!reset);

        idleCycle();
        expectOnBus("bus after reset", '0);
        for (int r = 0; r < 16; r++) begin
            drive(busSelect(regIndex_t'(r)), '0, '0, 1'b0);
            expectOnBus("register after reset", model[r]);
        end

        for (int k = 0; k < 3; k++) begin
            ra    = regIndex_t'(randomBits(4));
            value = randomBits(32);
            loadRegister(ra, value);
            drive(busSelect(ra), '0, '0, 1'b0);
            expectOnBus("register readback", value);
        end

        // fetch step moves PC to MAR while PC bumps
        pcStart     = randomBits(32);
        en          = '0;
        en.pcEnable = 1'b1;
        moveFromMemory(pcStart, en);
        sel         = '0;
        sel.pcOut   = 1'b1;
        en.marEnable = 1'b1;
        en.incPc     = 1'b1;
        drive(sel, en, '0, 1'b0);
        expectOnBus("fetch PC out", pcStart);
        drive(sel, '0, '0, 1'b0);
        expectOnBus("PC increment", pcStart + 32'd1);
        compareWord("fetch MAR", pcStart, marAddress);
        value       = randomBits(32);
        en          = '0;
        en.irEnable = 1'b1;
        moveFromMemory(value, en);
        idleCycle();
        compareWord("IR value", value, irValue);

        foreach (aluOps[k]) begin
            ra = regIndex_t'(randomBits(4));
            rb = regIndex_t'(randomBits(4));
            rc = regIndex_t'(randomBits(4));
            runAluOp($sformatf("ALU opcode %0d", aluOps[k]), aluOps[k], ra, rb, rc,
                     randomBits(32), randomBits(32));
        end
        runAluOp("shl R1 R3 R5", opShl, 4'd3, 4'd5, 4'd1, 32'd4, 32'd2);
        drive(busSelect(4'd1), '0, '0, 1'b0);
        expectOnBus("shl reference result", 32'd16);

        // with two registers and PC selected the lowest register must win
        ra    = regIndex_t'(randomBits(3));
        rb    = ra + 4'd1 + regIndex_t'(randomBits(3));
        value = randomBits(32);
        loadRegister(ra, value);
        loadRegister(rb, ~value);
        sel                = busSelect(ra);
        sel.generalOut[rb] = 1'b1;
        sel.pcOut          = 1'b1;
        drive(sel, '0, '0, 1'b0);
        expectOnBus("bus priority", model[ra]);

        value       = randomBits(32) | 32'h0004_0000;  // bit 18 set gives a negative constant
        en          = '0;
        en.irEnable = 1'b1;
        moveFromMemory(value, en);
        sel      = '0;
        sel.cOut = 1'b1;
        drive(sel, '0, '0, 1'b0);
        expectOnBus("C constant", signExtend19(value));

        value           = randomBits(32);
        en              = '0;
        en.inPortEnable = 1'b1;
        drive('0, en, '0, 1'b0);
        inPortData    = value;
        sel           = '0;
        sel.inPortOut = 1'b1;
        drive(sel, '0, '0, 1'b0);
        expectOnBus("input port", value);

        idleCycle();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== memoryInterface.sv ====
module memoryInterface (
    input  logic                Clock,
    input  logic                reset,
    input  logic                marEnable,
    input  logic                mdrEnable,
    input  logic                read,
    input  datapathPkg::word_t  busData,
    input  datapathPkg::word_t  memData,
    output datapathPkg::word_t  marAddress,
    output datapathPkg::word_t  mdrValue
);

    always_ff @(posedge Clock) begin
        if (reset) begin
            marAddress <= '0;
            mdrValue   <= '0;
        end else begin
            if (marEnable) begin
                marAddress <= busData;
            end
            if (mdrEnable) begin
                mdrValue <= read ? memData : busData;  // read strobe picks memory over bus
            end
        end
    end

endmodule

// ==== registerFile.sv ====
module registerFile #(
    parameter int numRegisters = 16
) (
    input  logic                     Clock,
    input  logic                     reset,
    input  datapathPkg::word_t       busData,
    input  logic [numRegisters-1:0]  generalEnable,
    input  logic [numRegisters-1:0]  generalOut,
    output datapathPkg::word_t       registerValue
);
    import datapathPkg::*;

    word_t registers [numRegisters];

    // each register has its own load strobe, several may load the same bus word
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < numRegisters; i++) begin
                registers[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegisters; i++) begin
                if (generalEnable[i]) begin
                    registers[i] <= busData;
                end
            end
        end
    end

    // scan from the top so the lowest selected index is written last and wins
    always_comb begin
        registerValue = '0;
        for (int i = numRegisters - 1; i >= 0; i--) begin
            if (generalOut[i]) begin
                registerValue = registers[i];
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module datapathTb -f datapath.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build stopped with status $status"
    exit $status
fi

./obj_dir/VdatapathTb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation stopped with status $status"
    exit $status
fi

exit 0

// ==== specialRegisters.sv ====
module specialRegisters (
    input  logic                       Clock,
    input  logic                       reset,
    input  datapathPkg::loadEnables_t  loads,
    input  datapathPkg::word_t         busData,
    input  datapathPkg::product_t      aluResult,
    input  datapathPkg::word_t         inPortData,
    output datapathPkg::word_t         pcValue,
    output datapathPkg::word_t         irValue,
    output datapathPkg::word_t         yValue,
    output datapathPkg::word_t         zHigh,
    output datapathPkg::word_t         zLow,
    output datapathPkg::word_t         hiValue,
    output datapathPkg::word_t         loValue,
    output datapathPkg::word_t         inPortValue
);
    import datapathPkg::*;

    product_t zValue;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcValue     <= '0;
            irValue     <= '0;
            yValue      <= '0;
            zValue      <= '0;
            hiValue     <= '0;
            loValue     <= '0;
            inPortValue <= '0;
        end else begin
            if (loads.pcEnable) begin
                pcValue <= loads.incPc ? busData + 32'd1 : busData;  // fetch step bumps PC
            end
            if (loads.irEnable) begin
                irValue <= busData;
            end
            if (loads.yEnable) begin
                yValue <= busData;  // ALU operand A
            end
            if (loads.zEnable) begin
                zValue <= aluResult;  // full 64 bits for mul/div
            end
            if (loads.hiEnable) begin
                hiValue <= busData;
            end
            if (loads.loEnable) begin
                loValue <= busData;
            end
            if (loads.inPortEnable) begin
                inPortValue <= inPortData;  // sampled from the pins, not the bus
            end
        end
    end

    assign zHigh = zValue[63:32];
    assign zLow  = zValue[31:0];

endmodule
